//--- dcache_top.f
source/dcache_pkg.sv
source/dcache_sram.sv
source/dcache_way_select.sv
source/dcache_ctrl.sv
source/dcache_top.sv
testbench/axi_mem_model.sv
testbench/dcache_assertions.sv
testbench/dcache_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the dcache testbench with verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module dcache_tb -f dcache_top.f -o dcache_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_output=$(./obj_dir/dcache_sim)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q '\*\*\* PASSED \*\*\*' <<< "$sim_output"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- source/dcache_ctrl.sv
module dcache_ctrl
	import dcache_pkg::*;
(
	input  logic                   clk,
	input  logic                   rst,
	// core side
	input  logic                   req_valid,
	input  core_req_t              req,
	output logic                   rsp_ready,
	output word_t                  rsp_data,
	// way selector
	input  logic                   hit,
	input  way_mask_t              hit_way,
	input  way_mask_t              victim_way,
	input  word_t                  hit_word,
	output logic                   idle,
	// ram control
	output logic [INDEX_W-1:0]     ram_index,
	output logic [WORD_SEL_W-1:0]  ram_word,
	output way_mask_t              tag_en,
	output logic                   tag_wr,
	output tag_entry_t             tag_wdata,
	output way_mask_t              data_en,
	output logic                   data_wr,
	output word_t                  data_wmask,
	output word_t                  data_wdata,
	// axi4 master
	output axi_ar_t                ar,
	output logic                   arvalid,
	input  logic                   arready,
	input  axi_r_t                 r,
	input  logic                   rvalid,
	output logic                   rready,
	output axi_aw_t                aw,
	output logic                   awvalid,
	input  logic                   awready,
	output axi_w_t                 w,
	output logic                   wvalid,
	input  logic                   wready,
	input  axi_b_t                 b,
	input  logic                   bvalid,
	output logic                   bready
);

	ctrl_state_t           state;
	ctrl_state_t           state_next;
	logic [INDEX_W-1:0]    clr_cnt;
	logic [WORD_SEL_W-1:0] beat_cnt;
	logic [TAG_W-1:0]      req_tag;
	logic [INDEX_W-1:0]    req_index;
	logic [WORD_SEL_W-1:0] req_word;
	word_t                 strb_mask;
	logic                  r_fire;

	// address fields: tag 31:10, set 9:6, word 5:3
	assign req_tag   = req.addr[ADDR_W-1 -: TAG_W];
	assign req_index = req.addr[ADDR_W-TAG_W-1 -: INDEX_W];
	assign req_word  = req.addr[ADDR_W-TAG_W-INDEX_W-1 -: WORD_SEL_W];

	// byte strobes widened to a bit mask
	always_comb begin
		for (int i = 0; i < 8; i++) begin
			strb_mask[8*i +: 8] = {8{req.strb[i]}};
		end
	end

	assign r_fire = (state == REFILL) && rvalid && rready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= CLEAR;
			clr_cnt  <= '0;
			beat_cnt <= '0;
		end else begin
			state <= state_next;
			if (state == CLEAR) begin
				clr_cnt <= clr_cnt + 1'b1;
			end
			// beat count restarts before every burst
			if (state == LOOKUP) begin
				beat_cnt <= '0;
			end else if (r_fire) begin
				beat_cnt <= beat_cnt + 1'b1;
			end
		end
	end

	// response word captured on a read hit
	always_ff @(posedge clk) begin
		if ((state == LOOKUP) && !req.wr && hit) begin
			rsp_data <= hit_word;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			CLEAR: begin
				if (clr_cnt == INDEX_W'(SETS - 1)) begin
					state_next = IDLE;
				end
			end
			IDLE: begin
				if (req_valid) begin
					state_next = LOOKUP;
				end
			end
			LOOKUP: begin
				// writes go to memory whether they hit or not
				if (req.wr) begin
					state_next = WR_ADDR;
				end else if (hit) begin
					state_next = RESPOND;
				end else if (arready) begin
					state_next = REFILL;
				end
			end
			REFILL: begin
				// back to idle, the repeated lookup then hits
				if (r_fire && r.last) begin
					state_next = IDLE;
				end
			end
			WR_ADDR: begin
				if (awready) begin
					state_next = WR_DATA;
				end
			end
			WR_DATA: begin
				if (wready) begin
					state_next = WR_RESP;
				end
			end
			WR_RESP: begin
				// any bresp finishes the write
				if (bvalid) begin
					state_next = RESPOND;
				end
			end
			RESPOND: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_comb begin
		ram_index  = req_index;
		ram_word   = req_word;
		tag_en     = '0;
		tag_wr     = 1'b0;
		tag_wdata  = '{valid: 1'b1, tag: req_tag};
		data_en    = '0;
		data_wr    = 1'b0;
		data_wmask = strb_mask;
		data_wdata = req.wdata;
		case (state)
			CLEAR: begin
				// one set per cycle, all ways at once
				ram_index = clr_cnt;
				tag_en    = '1;
				tag_wr    = 1'b1;
				tag_wdata = '0;
			end
			IDLE: begin
				// read every way, compare next cycle
				if (req_valid) begin
					tag_en  = '1;
					data_en = '1;
				end
			end
			LOOKUP: begin
				// write hit merges bytes into the hit way
				if (req.wr && hit) begin
					data_en = hit_way;
					data_wr = 1'b1;
				end
			end
			REFILL: begin
				ram_word   = beat_cnt;
				data_wmask = '1;
				data_wdata = r.data;
				if (r_fire) begin
					data_en = victim_way;
					data_wr = 1'b1;
					// tag goes valid with the final beat
					if (r.last) begin
						tag_en = victim_way;
						tag_wr = 1'b1;
					end
				end
			end
			default: begin
			end
		endcase
	end

	assign idle      = (state == IDLE);
	assign rsp_ready = (state == RESPOND);

	// lookup holds while arready is low, ram outputs stay put meanwhile
	assign arvalid = (state == LOOKUP) && !req.wr && !hit;
	assign ar = '{
		addr:  {req.addr[ADDR_W-1 -: TAG_W+INDEX_W], {(ADDR_W-TAG_W-INDEX_W){1'b0}}},
		len:   BURST_LEN,
		size:  BURST_SIZE,
		// incr burst
		burst: 2'b01
	};
	assign rready = 1'b1;

	// single beat write-through
	assign awvalid = (state == WR_ADDR);
	assign aw = '{
		addr:  {req.addr[ADDR_W-1 -: TAG_W+INDEX_W+WORD_SEL_W],
			{(ADDR_W-TAG_W-INDEX_W-WORD_SEL_W){1'b0}}},
		len:   8'd0,
		size:  BURST_SIZE,
		burst: 2'b01
	};

	assign wvalid = (state == WR_DATA);
	assign w = '{data: req.wdata, strb: req.strb, last: 1'b1};
	assign bready = 1'b1;

endmodule

//--- source/dcache_pkg.sv
package dcache_pkg;

	// cache geometry
	localparam int ADDR_W      = 32;
	localparam int WAYS        = 4;
	localparam int SETS        = 16;
	localparam int LINE_WORDS  = 8;
	localparam int INDEX_W     = 4;
	localparam int TAG_W       = 22;
	localparam int WORD_SEL_W  = 3;
	// data ram is indexed by {set, word}
	localparam int DATA_ADDR_W = 7;

	// refill burst is len+1 = 8 beats of 8 bytes
	localparam logic [7:0] BURST_LEN  = 8'd7;
	localparam logic [2:0] BURST_SIZE = 3'd3;

	typedef logic [63:0] word_t;
	typedef logic [7:0] strb_t;
	typedef logic [WAYS-1:0] way_mask_t;

	typedef struct packed {
		logic             valid;
		logic [TAG_W-1:0] tag;
	} tag_entry_t;

	// core load/store request
	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic              wr;
		word_t             wdata;
		strb_t             strb;
	} core_req_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_ar_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		logic [1:0]        burst;
	} axi_aw_t;

	typedef struct packed {
		word_t      data;
		logic [1:0] resp;
		logic       last;
	} axi_r_t;

	typedef struct packed {
		word_t data;
		strb_t strb;
		logic  last;
	} axi_w_t;

	typedef struct packed {
		logic [1:0] resp;
	} axi_b_t;

	// CLEAR sweeps the tag rams after reset
	typedef enum logic [2:0] {
		CLEAR,
		IDLE,
		LOOKUP,
		REFILL,
		WR_ADDR,
		WR_DATA,
		WR_RESP,
		RESPOND
	} ctrl_state_t;

endpackage

//--- source/dcache_sram.sv
module dcache_sram #(
	parameter type entry_t = logic [7:0],
	parameter int DEPTH = 16
) (
	input  logic                     clk,
	input  logic                     en,
	input  logic                     wr,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  entry_t                   wmask,
	input  entry_t                   wdata,
	output entry_t                   rdata
);

	// storage kept as flat vectors
	logic [$bits(entry_t)-1:0] mem [DEPTH];
	logic [$bits(entry_t)-1:0] mask_bits;
	logic [$bits(entry_t)-1:0] data_bits;

	assign mask_bits = wmask;
	assign data_bits = wdata;

	always_ff @(posedge clk) begin
		if (en) begin
			if (wr) begin
				// only masked bits change
				mem[addr] <= (mem[addr] & ~mask_bits) | (data_bits & mask_bits);
			end else begin
				// registered read, holds while not enabled
				rdata <= mem[addr];
			end
		end
	end

endmodule

//--- source/dcache_top.sv
module dcache_top
	import dcache_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	// core side
	input  logic      req_valid,
	input  core_req_t req,
	output logic      rsp_ready,
	output word_t     rsp_data,
	// axi4 memory port
	output axi_ar_t   ar,
	output logic      arvalid,
	input  logic      arready,
	input  axi_r_t    r,
	input  logic      rvalid,
	output logic      rready,
	output axi_aw_t   aw,
	output logic      awvalid,
	input  logic      awready,
	output axi_w_t    w,
	output logic      wvalid,
	input  logic      wready,
	input  axi_b_t    b,
	input  logic      bvalid,
	output logic      bready
);

	logic [INDEX_W-1:0]     ram_index;
	logic [WORD_SEL_W-1:0]  ram_word;
	logic [DATA_ADDR_W-1:0] data_addr;
	way_mask_t              tag_en;
	logic                   tag_wr;
	tag_entry_t             tag_wdata;
	way_mask_t              data_en;
	logic                   data_wr;
	word_t                  data_wmask;
	word_t                  data_wdata;
	tag_entry_t             tag_rdata [WAYS];
	word_t                  data_rdata [WAYS];
	logic                   hit;
	way_mask_t              hit_way;
	way_mask_t              victim_way;
	word_t                  hit_word;
	logic                   idle;

	// data ram row is set then word
	assign data_addr = {ram_index, ram_word};

	for (genvar i = 0; i < WAYS; i++) begin : g_way
		// tag entries, always fully written
		dcache_sram #(.entry_t(tag_entry_t), .DEPTH(SETS)) u_tag (
			.clk   (clk),
			.en    (tag_en[i]),
			.wr    (tag_wr),
			.addr  (ram_index),
			.wmask ('1),
			.wdata (tag_wdata),
			.rdata (tag_rdata[i])
		);
		dcache_sram #(.entry_t(word_t), .DEPTH(SETS * LINE_WORDS)) u_data (
			.clk   (clk),
			.en    (data_en[i]),
			.wr    (data_wr),
			.addr  (data_addr),
			.wmask (data_wmask),
			.wdata (data_wdata),
			.rdata (data_rdata[i])
		);
	end

	dcache_way_select u_way_select (
		.clk        (clk),
		.rst        (rst),
		.req_tag    (req.addr[ADDR_W-1 -: TAG_W]),
		.tags       (tag_rdata),
		.words      (data_rdata),
		.idle       (idle),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.hit_word   (hit_word)
	);

	dcache_ctrl u_ctrl (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req        (req),
		.rsp_ready  (rsp_ready),
		.rsp_data   (rsp_data),
		.hit        (hit),
		.hit_way    (hit_way),
		.victim_way (victim_way),
		.hit_word   (hit_word),
		.idle       (idle),
		.ram_index  (ram_index),
		.ram_word   (ram_word),
		.tag_en     (tag_en),
		.tag_wr     (tag_wr),
		.tag_wdata  (tag_wdata),
		.data_en    (data_en),
		.data_wr    (data_wr),
		.data_wmask (data_wmask),
		.data_wdata (data_wdata),
		.ar         (ar),
		.arvalid    (arvalid),
		.arready    (arready),
		.r          (r),
		.rvalid     (rvalid),
		.rready     (rready),
		.aw         (aw),
		.awvalid    (awvalid),
		.awready    (awready),
		.w          (w),
		.wvalid     (wvalid),
		.wready     (wready),
		.b          (b),
		.bvalid     (bvalid),
		.bready     (bready)
	);

endmodule

//--- source/dcache_way_select.sv
module dcache_way_select
	import dcache_pkg::*;
(
	input  logic             clk,
	input  logic             rst,
	input  logic [TAG_W-1:0] req_tag,
	input  tag_entry_t       tags [WAYS],
	input  word_t            words [WAYS],
	input  logic             idle,
	output logic             hit,
	output way_mask_t        hit_way,
	output way_mask_t        victim_way,
	output word_t            hit_word
);

	// one-hot replacement ring
	way_mask_t ring;

	// tag compare per way, invalid entries never hit
	always_comb begin
		for (int i = 0; i < WAYS; i++) begin
			hit_way[i] = tags[i].valid && (tags[i].tag == req_tag);
		end
	end

	assign hit = |hit_way;

	// and-or mux, hit_way is at most one-hot
	always_comb begin
		hit_word = '0;
		for (int i = 0; i < WAYS; i++) begin
			if (hit_way[i]) begin
				hit_word = hit_word | words[i];
			end
		end
	end

	// ring steps once per idle cycle
	// stays put through lookup and refill so the victim is stable
	always_ff @(posedge clk) begin
		if (rst) begin
			ring <= way_mask_t'(1);
		end else if (idle) begin
			ring <= {ring[WAYS-2:0], ring[WAYS-1]};
		end
	end

	assign victim_way = ring;

endmodule

//--- testbench/axi_mem_model.sv
module axi_mem_model
	import dcache_pkg::*;
(
	input  logic    clk,
	input  logic    rst,
	input  axi_ar_t ar,
	input  logic    arvalid,
	output logic    arready,
	output axi_r_t  r,
	output logic    rvalid,
	input  logic    rready,
	input  axi_aw_t aw,
	input  logic    awvalid,
	output logic    awready,
	input  axi_w_t  w,
	input  logic    wvalid,
	output logic    wready,
	output axi_b_t  b,
	output logic    bvalid,
	input  logic    bready
);
	timeunit 1ns;
	timeprecision 1ps;

	// 32 KiB of backing store, word addressed by addr[14:3]
	word_t ram [4096];

	logic [31:0] lfsr;
	logic [31:0] lfsr_1;
	logic [31:0] lfsr_2;
	logic [1:0]  rnd;
	logic [1:0]  ar_wait;
	logic [1:0]  aw_wait;
	logic [1:0]  w_wait;
	logic [1:0]  r_gap;
	logic        rd_active;
	logic [31:0] rd_addr;
	logic [2:0]  rd_beat;
	logic        aw_done;
	logic [31:0] wr_addr;

	// fibonacci lfsr, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// two steps give the two bits of a 0..3 delay
	assign lfsr_1 = lfsr_next(lfsr);
	assign lfsr_2 = lfsr_next(lfsr_1);
	assign rnd    = {lfsr_2[0], lfsr_1[0]};

	assign b = '{resp: 2'b00};

	always @(posedge clk) begin
		if (rst) begin
			lfsr      <= 32'h2b5a_b69e;
			arready   <= 1'b0;
			rvalid    <= 1'b0;
			r         <= '0;
			awready   <= 1'b0;
			wready    <= 1'b0;
			bvalid    <= 1'b0;
			rd_active <= 1'b0;
			rd_beat   <= 3'd0;
			aw_done   <= 1'b0;
			ar_wait   <= 2'd0;
			aw_wait   <= 2'd0;
			w_wait    <= 2'd0;
			r_gap     <= 2'd0;
		end else begin
			// read address, ready after a random wait
			if (arvalid && arready) begin
				arready   <= 1'b0;
				rd_active <= 1'b1;
				rd_addr   <= ar.addr;
				rd_beat   <= 3'd0;
				r_gap     <= rnd;
				ar_wait   <= rnd;
				lfsr      <= lfsr_2;
			end else if (arvalid && !rd_active) begin
				if (ar_wait == 2'd0) begin
					arready <= 1'b1;
				end else begin
					ar_wait <= ar_wait - 2'd1;
				end
			end
			// read beats, spaced by random gaps
			if (rd_active) begin
				if (rvalid && rready) begin
					rvalid <= 1'b0;
					r_gap  <= rnd;
					lfsr   <= lfsr_2;
					if (r.last) begin
						rd_active <= 1'b0;
					end else begin
						rd_beat <= rd_beat + 3'd1;
					end
				end else if (!rvalid) begin
					if (r_gap == 2'd0) begin
						rvalid <= 1'b1;
						r      <= '{data: ram[{rd_addr[14:6], rd_beat}], resp: 2'b00,
							last: (rd_beat == 3'd7)};
					end else begin
						r_gap <= r_gap - 2'd1;
					end
				end
			end
			// write address
			if (awvalid && awready) begin
				awready <= 1'b0;
				aw_done <= 1'b1;
				wr_addr <= aw.addr;
				aw_wait <= rnd;
				lfsr    <= lfsr_2;
			end else if (awvalid && !aw_done) begin
				if (aw_wait == 2'd0) begin
					awready <= 1'b1;
				end else begin
					aw_wait <= aw_wait - 2'd1;
				end
			end
			// write response lasts one cycle, bready is tied high
			if (bvalid && bready) begin
				bvalid <= 1'b0;
			end
			// write data, only after the address was taken
			if (wvalid && wready) begin
				wready  <= 1'b0;
				aw_done <= 1'b0;
				bvalid  <= 1'b1;
				w_wait  <= rnd;
				lfsr    <= lfsr_2;
				for (int i = 0; i < 8; i++) begin
					if (w.strb[i]) begin
						ram[wr_addr[14:3]][8*i +: 8] <= w.data[8*i +: 8];
					end
				end
			end else if (wvalid && aw_done) begin
				if (w_wait == 2'd0) begin
					wready <= 1'b1;
				end else begin
					w_wait <= w_wait - 2'd1;
				end
			end
		end
	end

endmodule

//--- testbench/dcache_assertions.sv
module dcache_assertions
	import dcache_pkg::*;
(
	input logic        clk,
	input logic        rst,
	input logic        arvalid,
	input logic        arready,
	input axi_ar_t     ar,
	input logic        awvalid,
	input logic        awready,
	input axi_aw_t     aw,
	input logic        wvalid,
	input logic        wready,
	input axi_w_t      w,
	input logic        rsp_ready,
	input way_mask_t   hit_way,
	input ctrl_state_t state
);
	timeunit 1ns;
	timeprecision 1ps;

	// count of failed properties
	int fail_count = 0;

	// valid holds with a stable payload until ready
	ar_hold: assert property (@(posedge clk) disable iff (rst)
		arvalid && !arready |=> arvalid && $stable(ar))
		else begin
			$error("ar channel changed before arready");
			fail_count++;
		end
	aw_hold: assert property (@(posedge clk) disable iff (rst)
		awvalid && !awready |=> awvalid && $stable(aw))
		else begin
			$error("aw channel changed before awready");
			fail_count++;
		end
	w_hold: assert property (@(posedge clk) disable iff (rst)
		wvalid && !wready |=> wvalid && $stable(w))
		else begin
			$error("w channel changed before wready");
			fail_count++;
		end

	// single cycle response pulse
	rsp_pulse: assert property (@(posedge clk) disable iff (rst)
		rsp_ready |=> !rsp_ready)
		else begin
			$error("rsp_ready held longer than one cycle");
			fail_count++;
		end

	// compare result only means something in lookup
	hit_onehot: assert property (@(posedge clk) disable iff (rst)
		state == LOOKUP |-> $onehot0(hit_way))
		else begin
			$error("more than one way hit");
			fail_count++;
		end

	// every reset or clear cycle is followed by a quiet response
	quiet_in_reset: assert property (@(posedge clk)
		rst || state == CLEAR |=> !rsp_ready)
		else begin
			$error("rsp_ready raised during reset or tag clear");
			fail_count++;
		end

endmodule

bind dcache_ctrl dcache_assertions u_assertions (.*);

//--- testbench/dcache_tb.sv
module dcache_tb
	import dcache_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	typedef struct packed {
		logic        wr;
		logic [31:0] addr;
		word_t       data;
		strb_t       strb;
		logic        expect_miss;
	} stim_t;

	localparam int NUM_STIM = 17;
	// reset, tag clear and some slack on top of the per-entry budget
	localparam int CYCLE_LIMIT = 40 * NUM_STIM + 8 + 16 + 20;

	// line a in set 1, line b in set 6, five lines share set 3
	stim_t stim [NUM_STIM] = '{
		'{1'b0, 32'h0000_1048, 64'h0, 8'h00, 1'b1},
		'{1'b0, 32'h0000_1060, 64'h0, 8'h00, 1'b0},
		'{1'b1, 32'h0000_1048, 64'h1122_3344_5566_7788, 8'h0f, 1'b0},
		'{1'b0, 32'h0000_1048, 64'h0, 8'h00, 1'b0},
		'{1'b1, 32'h0000_2190, 64'ha5a5_5a5a_c3c3_3c3c, 8'hf0, 1'b1},
		'{1'b0, 32'h0000_2190, 64'h0, 8'h00, 1'b1},
		'{1'b0, 32'h0000_2190, 64'h0, 8'h00, 1'b0},
		'{1'b0, 32'h0000_00c0, 64'h0, 8'h00, 1'b1},
		'{1'b0, 32'h0000_00c8, 64'h0, 8'h00, 1'b0},
		'{1'b0, 32'h0000_04d0, 64'h0, 8'h00, 1'b1},
		'{1'b0, 32'h0000_04d8, 64'h0, 8'h00, 1'b0},
		'{1'b0, 32'h0000_08e0, 64'h0, 8'h00, 1'b1},
		'{1'b0, 32'h0000_08e0, 64'h0, 8'h00, 1'b0},
		'{1'b0, 32'h0000_0cf8, 64'h0, 8'h00, 1'b1},
		'{1'b0, 32'h0000_0cc0, 64'h0, 8'h00, 1'b0},
		'{1'b0, 32'h0000_10c8, 64'h0, 8'h00, 1'b1},
		'{1'b0, 32'h0000_10f0, 64'h0, 8'h00, 1'b0}
	};

	logic      clk;
	logic      rst;
	logic      req_valid;
	core_req_t req;
	logic      rsp_ready;
	word_t     rsp_data;
	axi_ar_t   ar;
	logic      arvalid;
	logic      arready;
	axi_r_t    r;
	logic      rvalid;
	logic      rready;
	axi_aw_t   aw;
	logic      awvalid;
	logic      awready;
	axi_w_t    w;
	logic      wvalid;
	logic      wready;
	axi_b_t    b;
	logic      bvalid;
	logic      bready;

	// expected memory contents
	word_t shadow [4096];
	int    mismatches = 0;
	int    failures = 0;
	int    ar_count;
	int    aw_count;
	int    w_count;
	int    cycle_count = 0;

	dcache_top UUT (.*);

	axi_mem_model mem (.*);

	// address based fill, high half is the byte address
	function automatic word_t fill_word(input logic [31:0] addr);
		return {addr, ~addr};
	endfunction

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic check_ar(input axi_ar_t got, input axi_ar_t exp);
		if (got !== exp) begin
			$display("Mismatch ar: got %h expected %h", got, exp);
			mismatches++;
		end
	endtask

	task automatic check_aw(input axi_aw_t got, input axi_aw_t exp);
		if (got !== exp) begin
			$display("Mismatch aw: got %h expected %h", got, exp);
			mismatches++;
		end
	endtask

	task automatic check_w(input axi_w_t got, input axi_w_t exp);
		if (got !== exp) begin
			$display("Mismatch w: got %h expected %h", got, exp);
			mismatches++;
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			mismatches++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("%s", what);
		failures++;
	endtask

	initial begin
		clk = 1'b0;
		forever begin
			#50 clk = ~clk;
		end
	end

	// run limit
	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT) begin
			$display("run timed out after %0d cycles", cycle_count);
			$display("*** FAILED ***");
			$finish;
		end
	end

	// handshake monitors, sampled away from the rising edge
	always @(negedge clk) begin
		if (arvalid && arready) begin
			ar_count++;
			check_ar(ar, '{addr: {req.addr[31:6], 6'b0}, len: 8'd7, size: 3'd3,
				burst: 2'b01});
		end
		if (awvalid && awready) begin
			aw_count++;
			// single beat at the word address
			check_aw(aw, '{addr: {req.addr[31:3], 3'b0}, len: 8'd0, size: 3'd3,
				burst: 2'b01});
		end
		if (wvalid && wready) begin
			w_count++;
			check_w(w, '{data: req.wdata, strb: req.strb, last: 1'b1});
		end
		// read data and write responses are always accepted
		if (rvalid) begin
			check_bit("rready", rready, 1'b1);
		end
		if (bvalid) begin
			check_bit("bready", bready, 1'b1);
		end
	end

	initial begin
		stim_t       e;
		int          cycles;
		word_t       got;
		logic [11:0] idx;

		rst = 1'b1;
		req_valid = 1'b0;
		req = '0;
		for (int i = 0; i < 4096; i++) begin
			shadow[i] = fill_word(32'(i) << 3);
			mem.ram[i] = fill_word(32'(i) << 3);
		end
		repeat (8) @(posedge clk);
		#10 rst = 1'b0;
		// let the tag sweep finish
		repeat (17) @(posedge clk);
		#10;

		for (int n = 0; n < NUM_STIM; n++) begin
			e = stim[n];
			idx = e.addr[14:3];
			ar_count = 0;
			aw_count = 0;
			w_count = 0;
			req = '{addr: e.addr, wr: e.wr, wdata: e.data, strb: e.strb};
			req_valid = 1'b1;
			cycles = 0;
			do begin
				@(posedge clk);
				#10;
				cycles++;
			end while (!rsp_ready);
			got = rsp_data;
			req_valid = 1'b0;

			if (!e.wr) begin
				check_word("rsp_data", got, shadow[idx]);
				if (ar_count != (e.expect_miss ? 1 : 0)) begin
					report_failure($sformatf("read of %h issued %0d bursts", e.addr, ar_count));
				end
				if (!e.expect_miss && cycles != 2) begin
					report_failure($sformatf("read hit of %h answered after %0d cycles",
						e.addr, cycles));
				end
			end else begin
				for (int i = 0; i < 8; i++) begin
					if (e.strb[i]) begin
						shadow[idx][8*i +: 8] = e.data[8*i +: 8];
					end
				end
				check_word("memory word", mem.ram[idx], shadow[idx]);
				if (ar_count != 0 || aw_count != 1 || w_count != 1) begin
					report_failure($sformatf("write of %h gave %0d ar, %0d aw, %0d w",
						e.addr, ar_count, aw_count, w_count));
				end
			end
			// next request one cycle after the response
			@(posedge clk);
			#10;
		end

		$display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
			mismatches, failures, UUT.u_ctrl.u_assertions.fail_count);
		if (mismatches == 0 && failures == 0 && UUT.u_ctrl.u_assertions.fail_count == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule
